// File: io_soc.f
soc_pkg.sv
wb_if.sv
wb_addr_decode.sv
wb_reg_slave.sv
wb_resp_mux.sv
int_ctrl.sv
io_soc.sv
tb_io_soc.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the io_soc testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_io_soc -f io_soc.f

# The log decides pass or fail
./obj_dir/Vtb_io_soc > sim.log 2>&1 || true
cat sim.log

if grep -q "ALL CHECKS PASSED" sim.log; then
  exit 0
else
  exit 1
fi

// File: tb_io_soc.sv
// ##############################
// Testbench for the I/O backbone
// Register model and bus checks
// ##############################

`timescale 1ns/1ns

module tb_io_soc;

  localparam int DW   = soc_pkg::DATA_W;
  localparam int AW   = soc_pkg::ADDR_W;
  localparam int SW   = soc_pkg::SEL_W;
  localparam int NS   = soc_pkg::NUM_SLAVES;
  localparam int REGS = soc_pkg::REGS_PER_SLAVE;
  localparam int ACK_TIMEOUT  = 20;
  localparam int INTR_TIMEOUT = 20;

  logic           clk;
  logic           rst_lck;
  logic           cyc_i;
  logic           stb_i;
  logic           we_i;
  logic           tga_i;
  logic [SW-1:0]  sel_i;
  logic [AW-1:0]  adr_i;
  logic [DW-1:0]  dat_i;
  logic           inta_i;
  logic [DW-1:0]  dat_o;
  logic           ack_o;
  logic           intr_o;

  logic [DW-1:0]  model [NS][REGS];  // Expected register contents
  logic [NS-1:0]  model_pend;        // Expected pending interrupts
  logic [DW-1:0]  exp_dat;
  logic [DW-1:0]  exp_vec;
  logic           exp_lat;           // 1 for a block cycle, 0 for the default responder
  logic           db_exp;            // Current cycle is a doorbell write
  logic           post_rst;
  logic [31:0]    lcg_state;
  logic           rd_ack;
  logic           db_ack;

  io_soc #(
    .num_slaves (NS)
  ) io_soc_inst (
    .clk     (clk),
    .rst_lck (rst_lck),
    .cyc_i   (cyc_i),
    .stb_i   (stb_i),
    .we_i    (we_i),
    .tga_i   (tga_i),
    .sel_i   (sel_i),
    .adr_i   (adr_i),
    .dat_i   (dat_i),
    .dat_o   (dat_o),
    .ack_o   (ack_o),
    .inta_i  (inta_i),
    .intr_o  (intr_o)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  assign rd_ack = ack_o && cyc_i && stb_i && !we_i && !inta_i;
  assign db_ack = ack_o && cyc_i && stb_i && we_i && db_exp;

  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("CHECKS FAILED");
    $fatal(1, "simulation stopped at first error");
  endtask

  task automatic value_error(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    stop_on_error($sformatf("error at %0t ns: %s is %0h, expected %0h",
                            $time, name, got, exp));
  endtask

  // Bus and interrupt checks
  a_reset_quiet: assert property (@(posedge clk) post_rst |-> !ack_o && !intr_o)
    else value_error("ack_o|intr_o", {$sampled(ack_o), $sampled(intr_o)}, 0);

  a_read_data: assert property (@(posedge clk) disable iff (!rst_lck)
    rd_ack |-> dat_o == exp_dat)
    else value_error("dat_o", $sampled(dat_o), $sampled(exp_dat));

  a_default_ack: assert property (@(posedge clk) disable iff (!rst_lck)
    $rose(stb_i) && !exp_lat |-> ack_o)
    else value_error("ack_o", $sampled(ack_o), 1);

  a_block_wait: assert property (@(posedge clk) disable iff (!rst_lck)
    $rose(stb_i) && exp_lat |-> !ack_o)
    else value_error("ack_o", $sampled(ack_o), 0);

  a_block_ack: assert property (@(posedge clk) disable iff (!rst_lck)
    $past(stb_i) && !$past(stb_i, 2) && exp_lat |-> ack_o)
    else value_error("ack_o", $sampled(ack_o), 1);

  a_ack_single: assert property (@(posedge clk) disable iff (!rst_lck)
    $past(ack_o) && exp_lat |-> !ack_o)
    else value_error("ack_o", $sampled(ack_o), 0);

  a_intr_rise: assert property (@(posedge clk) disable iff (!rst_lck)
    $rose(intr_o) |-> $past(db_ack, 2))
    else stop_on_error($sformatf("intr_o rose at %0t ns without a doorbell", $time));

  a_intr_follow: assert property (@(posedge clk) disable iff (!rst_lck)
    $past(db_ack, 2) |-> intr_o)
    else value_error("intr_o", $sampled(intr_o), 1);

  a_vector: assert property (@(posedge clk) disable iff (!rst_lck)
    inta_i |-> dat_o == exp_vec)
    else value_error("dat_o", $sampled(dat_o), $sampled(exp_vec));

  a_intr_clear: assert property (@(posedge clk) disable iff (!rst_lck)
    $past(inta_i) |-> intr_o == (model_pend != '0))
    else value_error("intr_o", $sampled(intr_o), $sampled(model_pend) != '0);

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return {16'h0, lcg_state[31:16]};  // Upper half, better spread
  endfunction

  function automatic logic [AW-1:0] window_addr(input int blk, input int ofs);
    return soc_pkg::IO_BASE + AW'(blk) * soc_pkg::IO_STRIDE + AW'(ofs);
  endfunction

  // First set bit scanning up from index 0
  function automatic int lowest_index(input logic [NS-1:0] pend);
    int   idx;
    logic found;
    idx   = 0;
    found = 1'b0;
    for (int i = 0; i < NS; i++) begin
      if (pend[i] && !found) begin
        idx   = i;
        found = 1'b1;
      end
    end
    return idx;
  endfunction

  // One complete Wishbone cycle, held until ack_o
  task automatic run_cycle(input logic io, input logic wr, input logic [AW-1:0] adr,
                           input logic [SW-1:0] sel, input logic [DW-1:0] wdat,
                           input logic [DW-1:0] rexp, input logic mapped,
                           input logic db);
    int waited;
    waited = 0;
    @(posedge clk);
    cyc_i   <= 1'b1;
    stb_i   <= 1'b1;
    we_i    <= wr;
    tga_i   <= io;
    adr_i   <= adr;
    sel_i   <= sel;
    dat_i   <= wdat;
    exp_dat <= rexp;
    exp_lat <= mapped;
    db_exp  <= db;
    @(posedge clk);
    while (ack_o !== 1'b1) begin
      if (waited == ACK_TIMEOUT)
        stop_on_error($sformatf("timeout, no ack_o for address %0h", adr));
      waited++;
      @(posedge clk);
    end
    cyc_i <= 1'b0;
    stb_i <= 1'b0;
    we_i  <= 1'b0;
  endtask

  task automatic write_reg(input int blk, input int ofs, input logic [SW-1:0] sel,
                           input logic [DW-1:0] data);
    logic [DW-1:0] lane_mask;
    run_cycle(1'b1, 1'b1, window_addr(blk, ofs), sel, data, '0, 1'b1,
              ofs == soc_pkg::DOORBELL_REG);
    for (int b = 0; b < SW; b++) begin
      lane_mask[8*b +: 8] = {8{sel[b]}};
    end
    model[blk][ofs] = (model[blk][ofs] & ~lane_mask) | (data & lane_mask);
    if (ofs == soc_pkg::DOORBELL_REG)
      model_pend <= model_pend | (NS'(1) << blk);
  endtask

  task automatic read_reg(input int blk, input int ofs);
    run_cycle(1'b1, 1'b0, window_addr(blk, ofs), '1, DW'(next_rand()),
              model[blk][ofs], 1'b1, 1'b0);
  endtask

  task automatic sweep_regs();
    for (int b = 0; b < NS; b++) begin
      for (int o = 0; o < REGS; o++) begin
        read_reg(b, o);
      end
    end
  endtask

  // Memory cycle, or I/O cycle that misses every window
  task automatic stray_cycle(input logic io, input logic [AW-1:0] adr);
    run_cycle(io, next_rand() % 2, adr, SW'(next_rand()), DW'(next_rand()),
              soc_pkg::DEFAULT_DATA, 1'b0, 1'b0);
  endtask

  task automatic wait_intr(input logic level);
    int waited;
    waited = 0;
    @(posedge clk);
    while (intr_o !== level) begin
      if (waited == INTR_TIMEOUT)
        stop_on_error($sformatf("timeout, intr_o never went to %0b", level));
      waited++;
      @(posedge clk);
    end
  endtask

  task automatic int_ack();
    int iid;
    iid = lowest_index(model_pend);
    @(posedge clk);
    inta_i  <= 1'b1;
    exp_vec <= {soc_pkg::VEC_BASE, soc_pkg::IID_W'(iid)};
    @(posedge clk);
    inta_i     <= 1'b0;
    model_pend <= model_pend & ~(NS'(1) << iid);
    repeat (3) @(posedge clk);
  endtask

  initial begin
    int blk;
    int ofs;
    int skip;
    rst_lck    = 1'b0;
    cyc_i      = 1'b0;
    stb_i      = 1'b0;
    we_i       = 1'b0;
    tga_i      = 1'b0;
    sel_i      = '0;
    adr_i      = '0;
    dat_i      = '0;
    inta_i     = 1'b0;
    exp_dat    = '0;
    exp_vec    = '0;
    exp_lat    = 1'b0;
    db_exp     = 1'b0;
    post_rst   = 1'b0;
    model_pend = '0;
    lcg_state  = 32'h67d40ac9;
    for (int b = 0; b < NS; b++) begin
      for (int o = 0; o < REGS; o++) begin
        model[b][o] = '0;
      end
    end

    repeat (5) @(posedge clk);
    rst_lck  <= 1'b1;
    post_rst <= 1'b1;
    repeat (2) @(posedge clk);
    post_rst <= 1'b0;
    sweep_regs();  // Everything reads zero

    // Random write then read back, doorbell left out
    repeat (40) begin
      blk = next_rand() % NS;
      ofs = next_rand() % soc_pkg::DOORBELL_REG;
      write_reg(blk, ofs, SW'(next_rand()), DW'(next_rand()));
      read_reg(blk, ofs);
    end
    sweep_regs();

    repeat (16) begin
      case (next_rand() % 3)
        0: stray_cycle(1'b0, AW'(next_rand() * 8));
        1: stray_cycle(1'b1, window_addr(next_rand() % NS, 8 + next_rand() % 8));
        default: stray_cycle(1'b1, AW'(next_rand() % soc_pkg::IO_BASE));
      endcase
    end
    stray_cycle(1'b0, window_addr(0, 0));  // Window address, memory tag
    sweep_regs();

    // Doorbells on every block but one, highest first, then drain by priority
    skip = next_rand() % NS;
    for (int b = NS - 1; b >= 0; b--) begin
      if (b != skip) begin
        write_reg(b, soc_pkg::DOORBELL_REG, '1, DW'(next_rand()));
        repeat (4) @(posedge clk);
      end
    end
    wait_intr(1'b1);
    for (int n = 0; n < NS && model_pend != '0; n++) begin
      int_ack();
    end
    wait_intr(1'b0);
    sweep_regs();

    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule

// File: io_soc.sv
// ##############################
// I/O backbone top level
// Decoder, blocks, mux and PIC
// ##############################

`timescale 1ns/1ns

module io_soc #(
  parameter int num_slaves = soc_pkg::NUM_SLAVES
) (
  input  logic                        clk,
  input  logic                        rst_lck,

  // Bus master port
  input  logic                        cyc_i,
  input  logic                        stb_i,
  input  logic                        we_i,
  input  logic                        tga_i,    // 1 for I/O, 0 for memory
  input  logic [soc_pkg::SEL_W-1:0]   sel_i,
  input  logic [soc_pkg::ADDR_W-1:0]  adr_i,
  input  logic [soc_pkg::DATA_W-1:0]  dat_i,
  output logic [soc_pkg::DATA_W-1:0]  dat_o,
  output logic                        ack_o,

  // Interrupt handshake
  input  logic                        inta_i,
  output logic                        intr_o
);

  logic [num_slaves-1:0]       hit;
  logic [num_slaves-1:0]       irq;
  logic [num_slaves-1:0]       irq_clr;
  logic [soc_pkg::DATA_W-1:0]  vector;

  wb_if bus_if [num_slaves] ();

  wb_addr_decode #(
    .num_slaves (num_slaves)
  ) u_decode (
    .cyc_i (cyc_i),
    .stb_i (stb_i),
    .we_i  (we_i),
    .sel_i (sel_i),
    .adr_i (adr_i),
    .tga_i (tga_i),
    .dat_i (dat_i),
    .slv   (bus_if),
    .hit_o (hit)
  );

  for (genvar k = 0; k < num_slaves; k++) begin : g_blk
    wb_reg_slave u_regs (
      .clk       (clk),
      .rst_lck   (rst_lck),
      .bus       (bus_if[k]),
      .irq_o     (irq[k]),
      .irq_clr_i (irq_clr[k])
    );
  end

  wb_resp_mux #(
    .num_slaves (num_slaves)
  ) u_resp (
    .slv      (bus_if),
    .hit_i    (hit),
    .cyc_i    (cyc_i),
    .stb_i    (stb_i),
    .inta_i   (inta_i),
    .vector_i (vector),
    .dat_o    (dat_o),
    .ack_o    (ack_o)
  );

  // Identifier only reaches the bus inside the vector
  int_ctrl #(
    .num_slaves (num_slaves)
  ) u_pic (
    .clk      (clk),
    .rst_lck  (rst_lck),
    .irq_i    (irq),
    .inta_i   (inta_i),
    .intr_o   (intr_o),
    .iid_o    (),
    .vector_o (vector),
    .clr_o    (irq_clr)
  );

endmodule

// File: int_ctrl.sv
// ##############################
// Priority interrupt controller
// Lowest index wins
// ##############################

`timescale 1ns/1ns

module int_ctrl #(
  parameter int num_slaves = soc_pkg::NUM_SLAVES
) (
  input  logic                        clk,
  input  logic                        rst_lck,
  input  logic [num_slaves-1:0]       irq_i,
  input  logic                        inta_i,
  output logic                        intr_o,
  output logic [soc_pkg::IID_W-1:0]   iid_o,
  output logic [soc_pkg::DATA_W-1:0]  vector_o,
  output logic [num_slaves-1:0]       clr_o      // One-hot, back to the blocks
);

  localparam int IW = soc_pkg::IID_W;

  logic [num_slaves-1:0] pending;

  // Source is still high on the clearing edge, so mask after the merge
  always_ff @(posedge clk) begin
    if (!rst_lck) begin
      pending <= '0;
    end else begin
      pending <= (pending | irq_i) & ~clr_o;
    end
  end

  assign intr_o = |pending;

  always_comb begin
    iid_o = '0;
    for (int i = num_slaves - 1; i >= 0; i--) begin
      if (pending[i]) iid_o = IW'(i);
    end
  end

  // Isolate lowest set bit
  assign clr_o    = inta_i ? (pending & (~pending + 1'b1)) : '0;
  assign vector_o = {soc_pkg::VEC_BASE, iid_o};

  // Master only acknowledges a raised request
  a_inta_needs_intr: assert property (
    @(posedge clk) disable iff (!rst_lck)
    inta_i |-> intr_o
  ) else $error("int_ctrl: inta without pending request");

endmodule

// File: wb_resp_mux.sv
// ##############################
// Wishbone response multiplexer
// Block, default or int vector
// ##############################

`timescale 1ns/1ns

module wb_resp_mux #(
  parameter int num_slaves = soc_pkg::NUM_SLAVES
) (
  wb_if.resp                          slv [num_slaves],

  input  logic [num_slaves-1:0]       hit_i,    // One-hot, zero for default
  input  logic                        cyc_i,
  input  logic                        stb_i,
  input  logic                        inta_i,
  input  logic [soc_pkg::DATA_W-1:0]  vector_i,

  output logic [soc_pkg::DATA_W-1:0]  dat_o,
  output logic                        ack_o
);

  localparam int DW = soc_pkg::DATA_W;

  logic [num_slaves-1:0] s_ack;
  logic [DW-1:0]         s_dat [num_slaves];
  logic [DW-1:0]         bus_dat;

  // Flatten the interface array
  for (genvar k = 0; k < num_slaves; k++) begin : g_col
    assign s_ack[k] = slv[k].ack;
    assign s_dat[k] = slv[k].dat_r;
  end

  always_comb begin
    // Default responder acks at once, writes dropped
    ack_o   = cyc_i & stb_i;
    bus_dat = soc_pkg::DEFAULT_DATA;
    for (int k = 0; k < num_slaves; k++) begin
      if (hit_i[k]) begin
        ack_o   = s_ack[k];
        bus_dat = s_dat[k];
      end
    end
  end

  // Vector replaces bus data during interrupt acknowledge
  assign dat_o = inta_i ? vector_i : bus_dat;

endmodule

// File: wb_reg_slave.sv
// ##############################
// I/O register block
// 8 regs, byte lanes, doorbell
// ##############################

`timescale 1ns/1ns

module wb_reg_slave (
  input  logic  clk,
  input  logic  rst_lck,

  wb_if.slave   bus,

  output logic  irq_o,
  input  logic  irq_clr_i  // From the interrupt controller
);

  localparam int DW    = soc_pkg::DATA_W;
  localparam int OFS_W = $clog2(soc_pkg::REGS_PER_SLAVE);
  localparam logic [OFS_W-1:0] DB_OFS = soc_pkg::DOORBELL_REG[OFS_W-1:0];

  logic [DW-1:0]     regs [soc_pkg::REGS_PER_SLAVE];
  logic [OFS_W-1:0]  ofs;
  logic              req;
  logic              ack_q;
  logic              done_q;   // Cycle acked, waiting for stb to drop
  logic              accept;
  logic              ring;

  assign ofs    = bus.adr[OFS_W-1:0];
  assign req    = bus.cyc & bus.stb;
  assign accept = req & ~ack_q & ~done_q;
  assign ring   = ack_q & bus.we & (ofs == DB_OFS);  // Doorbell write completing

  always_ff @(posedge clk) begin
    if (!rst_lck) begin
      ack_q  <= 1'b0;
      done_q <= 1'b0;
    end else begin
      ack_q  <= accept;
      done_q <= req & (done_q | ack_q);
    end
  end

  // Write lands on the same edge the ack rises
  always_ff @(posedge clk) begin
    if (!rst_lck) begin
      for (int i = 0; i < soc_pkg::REGS_PER_SLAVE; i++) begin
        regs[i] <= '0;
      end
    end else if (accept && bus.we) begin
      for (int b = 0; b < soc_pkg::SEL_W; b++) begin
        if (bus.sel[b]) regs[ofs][8*b +: 8] <= bus.dat_w[8*b +: 8];
      end
    end
  end

  // Doorbell holds until the controller takes it
  always_ff @(posedge clk) begin
    if (!rst_lck) begin
      irq_o <= 1'b0;
    end else begin
      irq_o <= (irq_o & ~irq_clr_i) | ring;
    end
  end

  assign bus.ack   = ack_q;
  assign bus.dat_r = regs[ofs];  // Request held stable, so valid with ack

  // Ack only answers a request seen the cycle before
  a_ack_after_req: assert property (
    @(posedge clk) disable iff (!rst_lck)
    bus.ack |-> $past(bus.cyc & bus.stb)
  ) else $error("wb_reg_slave: ack without request");

endmodule

// File: wb_addr_decode.sv
// ##############################
// Wishbone address decoder
// Steers I/O cycles to a block
// ##############################

`timescale 1ns/1ns

module wb_addr_decode #(
  parameter int num_slaves = soc_pkg::NUM_SLAVES
) (
  input  logic                        cyc_i,
  input  logic                        stb_i,
  input  logic                        we_i,
  input  logic [soc_pkg::SEL_W-1:0]   sel_i,
  input  logic [soc_pkg::ADDR_W-1:0]  adr_i,
  input  logic                        tga_i,   // High marks an I/O cycle
  input  logic [soc_pkg::DATA_W-1:0]  dat_i,

  wb_if.master                        slv [num_slaves],

  output logic [num_slaves-1:0]       hit_o
);

  localparam int AW = soc_pkg::ADDR_W;

  logic [AW-1:0] adr_win;  // Address with offset bits stripped

  assign adr_win = adr_i & soc_pkg::IO_MASK;

  for (genvar k = 0; k < num_slaves; k++) begin : g_win
    localparam logic [AW-1:0] WIN_BASE = soc_pkg::IO_BASE + AW'(k) * soc_pkg::IO_STRIDE;

    // Memory cycles never hit a block
    assign hit_o[k] = tga_i && (adr_win == WIN_BASE);

    // Strobes only reach the matching block
    assign slv[k].cyc   = cyc_i & hit_o[k];
    assign slv[k].stb   = stb_i & hit_o[k];
    assign slv[k].we    = we_i;
    assign slv[k].sel   = sel_i;
    assign slv[k].adr   = adr_i;
    assign slv[k].dat_w = dat_i;
  end

  // Windows from the package map must never overlap
  always_comb begin
    assert ($onehot0(hit_o))
      else $error("wb_addr_decode: overlapping windows, hit_o=%b", hit_o);
  end

endmodule

// File: wb_if.sv
// ##############################
// Wishbone point to point link
// ##############################

`timescale 1ns/1ns

interface wb_if;

  logic                        cyc;
  logic                        stb;
  logic                        we;
  logic [soc_pkg::SEL_W-1:0]   sel;
  logic [soc_pkg::ADDR_W-1:0]  adr;
  logic [soc_pkg::DATA_W-1:0]  dat_w;  // Master to slave
  logic [soc_pkg::DATA_W-1:0]  dat_r;  // Slave to master
  logic                        ack;

  modport master (
    output cyc, stb, we, sel, adr, dat_w,
    input  dat_r, ack
  );

  modport slave (
    input  cyc, stb, we, sel, adr, dat_w,
    output dat_r, ack
  );

  // Response side only, drives nothing
  modport resp (
    input dat_r, ack
  );

endinterface

// File: soc_pkg.sv
// ##############################
// I/O backbone shared constants
// Bus widths, window map, vectors
// ##############################

package soc_pkg;

  // Bus geometry
  localparam int DATA_W = 16;
  localparam int ADDR_W = 19;  // Word address, byte bits 19..1
  localparam int SEL_W  = 2;   // One select per byte lane

  // Register blocks
  localparam int NUM_SLAVES     = 4;
  localparam int REGS_PER_SLAVE = 8;
  localparam int DOORBELL_REG   = 7;  // Write here raises the block irq

  // I/O window map, all in word addresses
  // Block k sits at byte port 0xF000 + k*0x20
  localparam logic [ADDR_W-1:0] IO_BASE   = 19'h07800;
  localparam logic [ADDR_W-1:0] IO_STRIDE = 19'd16;
  localparam logic [ADDR_W-1:0] IO_MASK   = 19'h7fff8;  // 8 words per window

  // Unmapped space reads as all ones
  localparam logic [DATA_W-1:0] DEFAULT_DATA = 16'hffff;

  // Interrupt vector is {VEC_BASE, iid}
  localparam int                       IID_W    = 3;
  localparam logic [DATA_W-IID_W-1:0]  VEC_BASE = 13'd1;

endpackage
